//--- verilog/img_pkg.sv
package img_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int PIXEL_BITS   = 12;
    localparam int WORD_BITS    = 16;
    localparam int FB_ADDR_BITS = 16;
    localparam int STAT_BITS    = 18;

    typedef logic [PIXEL_BITS-1:0]   pixel_t;
    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;
    // One extra bit so a full 65536-word frame can be counted
    typedef logic [FB_ADDR_BITS:0]   pix_count_t;
    typedef logic [STAT_BITS-1:0]    stat_count_t;
    typedef logic [2*WORD_BITS-1:0]  checksum_t;
    typedef logic [1:0]              skip_t;

    // ========================================================================
    // Bundles
    // ========================================================================
    typedef struct packed {
        logic   fv;
        logic   lv;
        pixel_t d;
    } pix_in_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        word_t    data;
    } fb_write_t;

    typedef struct packed {
        pix_count_t  pixel_count;
        stat_count_t highlight_count;
        stat_count_t shadow_count;
    } capture_stats_t;

    // State machines
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_FRAME,
        CAP_STORE,
        CAP_DONE
    } capture_state_e;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_HEADER,
        RD_PIXELS,
        RD_DRAIN,
        RD_TRAILER,
        RD_DONE
    } readout_state_e;

endpackage

//--- verilog/pixel_capture.sv
`timescale 1ns/100ps

module pixel_capture
    import img_pkg::*;
#(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  pix_in_t        pix,
    input  logic           capture_req,
    input  skip_t          skip_count,
    output logic           capture_ack,
    output capture_stats_t stats,
    output fb_write_t      wr
);

    localparam int PIX_COUNT = IMG_WIDTH * IMG_HEIGHT;

    capture_state_e state;
    logic           fv_q;
    logic           lv_q;
    // Position inside the 4x4 sampling grid
    logic [1:0]     x;
    logic [1:0]     y;
    skip_t          skip_left;

    logic           frame_start;
    logic           storing;
    logic           sample;
    logic [6:0]     top_bits;

    assign frame_start = pix.fv && !fv_q;

    // The first cycle of the wanted frame is already stored
    assign storing = (state == CAP_STORE) ||
                     (state == CAP_WAIT_FRAME && frame_start && skip_left == '0);

    // Word count doubles as the write address
    assign wr.en   = storing && pix.fv && pix.lv &&
                     (stats.pixel_count < pix_count_t'(PIX_COUNT));
    assign wr.addr = stats.pixel_count[FB_ADDR_BITS-1:0];
    // Little endian with the low pixel byte first
    assign wr.data = {pix.d[7:0], 4'b0000, pix.d[PIXEL_BITS-1:8]};

    assign top_bits = pix.d[PIXEL_BITS-1 -: 7];
    assign sample   = wr.en && x == 2'd0 && y == 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= CAP_IDLE;
            capture_ack <= 1'b0;
            fv_q        <= 1'b0;
            lv_q        <= 1'b0;
            x           <= '0;
            y           <= '0;
            skip_left   <= '0;
            stats       <= '0;
        end else begin
            fv_q <= pix.fv;
            lv_q <= pix.lv;

            if (!pix.lv) x <= '0;
            else         x <= x + 2'd1;

            // Line ends on lv falling
            if (!pix.fv)              y <= '0;
            else if (lv_q && !pix.lv) y <= y + 2'd1;

            if (wr.en) stats.pixel_count <= stats.pixel_count + 1'b1;
            if (sample && top_bits == '1) stats.highlight_count <= stats.highlight_count + 1'b1;
            if (sample && top_bits == '0) stats.shadow_count <= stats.shadow_count + 1'b1;

            case (state)
                CAP_IDLE: begin
                    if (capture_req) begin
                        stats     <= '0;
                        skip_left <= skip_count;
                        state     <= CAP_WAIT_FRAME;
                    end
                end
                CAP_WAIT_FRAME: begin
                    if (frame_start) begin
                        if (skip_left == '0) state <= CAP_STORE;
                        else                 skip_left <= skip_left - 1'b1;
                    end
                end
                CAP_STORE: begin
                    if (!pix.fv) begin
                        capture_ack <= 1'b1;
                        state       <= CAP_DONE;
                    end
                end
                default: begin
                    if (!capture_req) begin
                        capture_ack <= 1'b0;
                        state       <= CAP_IDLE;
                    end
                end
            endcase
        end
    end

    // A write never takes the word count past the end of the frame buffer
    assert property (@(posedge clk) disable iff (!rst_n)
        wr.en |=> stats.pixel_count <= pix_count_t'(PIX_COUNT));

endmodule

//--- verilog/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer
    import img_pkg::*;
#(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 16
) (
    input  logic      clk,
    input  fb_write_t wr,
    input  fb_addr_t  rd_addr,
    output word_t     rd_data
);

    localparam int DEPTH     = IMG_WIDTH * IMG_HEIGHT;
    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t mem [DEPTH];

    // One write port, one registered read port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[ADDR_BITS-1:0]] <= wr.data;
        end
        rd_data <= mem[rd_addr[ADDR_BITS-1:0]];
    end

endmodule

//--- verilog/fletcher_checksum.sv
`timescale 1ns/100ps

module fletcher_checksum
    import img_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      en,
    input  word_t     din,
    output checksum_t sum
);

    localparam logic [WORD_BITS:0] MODULUS = {1'b0, {WORD_BITS{1'b1}}};

    word_t sum_a;
    word_t sum_b;
    word_t next_a;
    word_t next_b;

    // Addition mod 65535 with a single correction step
    function automatic word_t add_mod(input word_t lhs, input word_t rhs);
        logic [WORD_BITS:0] s;
        s = lhs + rhs;
        if (s >= MODULUS) s = s - MODULUS;
        return s[WORD_BITS-1:0];
    endfunction

    always_comb begin
        next_a = add_mod(sum_a, din);
        next_b = add_mod(sum_b, next_a);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            sum_b <= next_b;
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

//--- verilog/readout_sequencer.sv
`timescale 1ns/100ps

module readout_sequencer
    import img_pkg::*;
#(
    parameter int IMG_WIDTH     = 16,
    parameter int IMG_HEIGHT    = 16,
    parameter int HEADER_WORDS  = 8,
    parameter int PADDING_WORDS = 42
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     readout_req,
    input  logic                     thumb,
    input  word_t [HEADER_WORDS-1:0] header,
    output logic                     readout_ack,
    output fb_addr_t                 rd_addr,
    input  word_t                    rd_data,
    output logic                     out_valid,
    output word_t                    out_data,
    input  logic                     out_ready
);

    localparam int PIX_COUNT     = IMG_WIDTH * IMG_HEIGHT;
    localparam int TRAILER_WORDS = PADDING_WORDS + 2;

    readout_state_e           state;
    word_t [HEADER_WORDS-1:0] hdr_q;
    checksum_t                trailer_q;
    pix_count_t               cnt;
    fb_addr_t                 addr_q;
    fb_addr_t                 x;
    fb_addr_t                 y;
    logic                     thumb_q;

    logic                     load_ok;
    logic                     keep;
    logic                     consume;
    logic                     last;
    logic                     cs_clear;
    logic                     cs_en;
    word_t                    cs_din;
    checksum_t                cs_sum;

    // ========================================================================
    // Output register and buffer read control
    // ========================================================================
    // Register free now or emptied this cycle
    assign load_ok = !out_valid || out_ready;
    // Thumbnail keeps the top-left 2x2 of every 8x8 block
    assign keep    = !thumb_q || (x[2:1] == 2'b00 && y[2:1] == 2'b00);
    // Skipped pixels are dropped without waiting for the consumer
    assign consume = (state == RD_PIXELS) && (!keep || load_ok);
    assign last    = (cnt == pix_count_t'(1));
    // Next address goes out early so rd_data tracks addr_q
    assign rd_addr = consume ? addr_q + 1'b1 : addr_q;

    assign cs_clear = (state == RD_IDLE) && readout_req;
    assign cs_en    = load_ok && ((state == RD_HEADER) || (state == RD_PIXELS && keep));
    // Words are summed byte-swapped
    assign cs_din   = (state == RD_HEADER) ? {hdr_q[0][7:0], hdr_q[0][15:8]} :
                                             {rd_data[7:0], rd_data[15:8]};

    fletcher_checksum checksum_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cs_clear),
        .en    (cs_en),
        .din   (cs_din),
        .sum   (cs_sum)
    );

    // ========================================================================
    // Readout FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= RD_IDLE;
            readout_ack <= 1'b0;
            out_valid   <= 1'b0;
            cnt         <= '0;
            addr_q      <= '0;
            x           <= '0;
            y           <= '0;
            thumb_q     <= 1'b0;
        end else begin
            if (out_valid && out_ready) out_valid <= 1'b0;

            case (state)
                RD_IDLE: begin
                    if (readout_req) begin
                        thumb_q <= thumb;
                        addr_q  <= '0;
                        x       <= '0;
                        y       <= '0;
                        cnt     <= pix_count_t'(HEADER_WORDS);
                        state   <= RD_HEADER;
                    end
                end
                RD_HEADER: begin
                    if (load_ok) begin
                        out_valid <= 1'b1;
                        cnt       <= cnt - 1'b1;
                        if (last) begin
                            cnt   <= pix_count_t'(PIX_COUNT);
                            state <= RD_PIXELS;
                        end
                    end
                end
                RD_PIXELS: begin
                    if (consume) begin
                        addr_q <= rd_addr;
                        cnt    <= cnt - 1'b1;
                        if (keep) out_valid <= 1'b1;
                        if (x == fb_addr_t'(IMG_WIDTH - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        if (last) state <= RD_DRAIN;
                    end
                end
                // Last checksum update lands during this cycle
                RD_DRAIN: begin
                    cnt   <= pix_count_t'(TRAILER_WORDS);
                    state <= RD_TRAILER;
                end
                RD_TRAILER: begin
                    if (load_ok) begin
                        out_valid <= 1'b1;
                        cnt       <= cnt - 1'b1;
                        if (last) state <= RD_DONE;
                    end
                end
                default: begin
                    if (!readout_ack && load_ok) begin
                        readout_ack <= 1'b1;
                    end else if (readout_ack && !readout_req) begin
                        readout_ack <= 1'b0;
                        state       <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        case (state)
            RD_IDLE: hdr_q <= header;
            RD_HEADER: begin
                if (load_ok) begin
                    out_data <= hdr_q[0];
                    hdr_q    <= hdr_q >> WORD_BITS;
                end
            end
            RD_PIXELS: begin
                if (consume && keep) out_data <= rd_data;
            end
            // Byte-reversed checksum with zeros shifting in behind it as padding
            RD_DRAIN: trailer_q <= {cs_sum[7:0], cs_sum[15:8], cs_sum[23:16], cs_sum[31:24]};
            RD_TRAILER: begin
                if (load_ok) begin
                    out_data  <= trailer_q[2*WORD_BITS-1:WORD_BITS];
                    trailer_q <= trailer_q << WORD_BITS;
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(readout_ack) |-> readout_req);

endmodule

//--- verilog/img_controller.sv
`timescale 1ns/100ps

module img_controller
    import img_pkg::*;
#(
    parameter int IMG_WIDTH     = 16,
    parameter int IMG_HEIGHT    = 16,
    parameter int HEADER_WORDS  = 8,
    parameter int PADDING_WORDS = 42
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pix_in_t                  pix,
    input  logic                     capture_req,
    input  skip_t                    skip_count,
    output logic                     capture_ack,
    output capture_stats_t           stats,
    input  logic                     readout_req,
    input  logic                     thumb,
    input  word_t [HEADER_WORDS-1:0] header,
    output logic                     readout_ack,
    output logic                     out_valid,
    output word_t                    out_data,
    input  logic                     out_ready
);

    fb_write_t wr;
    fb_addr_t  rd_addr;
    word_t     rd_data;

    // Sensor side
    pixel_capture #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) capture_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix         (pix),
        .capture_req (capture_req),
        .skip_count  (skip_count),
        .capture_ack (capture_ack),
        .stats       (stats),
        .wr          (wr)
    );

    frame_buffer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) buffer_i (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Host side
    readout_sequencer #(
        .IMG_WIDTH     (IMG_WIDTH),
        .IMG_HEIGHT    (IMG_HEIGHT),
        .HEADER_WORDS  (HEADER_WORDS),
        .PADDING_WORDS (PADDING_WORDS)
    ) readout_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .readout_req (readout_req),
        .thumb       (thumb),
        .header      (header),
        .readout_ack (readout_ack),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

endmodule

//--- verification/img_model.svh
`ifndef IMG_MODEL_SVH
`define IMG_MODEL_SVH

// Last frame sent to the sensor port in raster order
pixel_t    frame_model [PIX_COUNT];
word_t     exp_stream [$];
checksum_t exp_trailer;

// Low pixel byte in the upper half and high nibble in the lower half
function automatic word_t pack_pixel(input pixel_t p);
    return {p[7:0], 4'h0, p[11:8]};
endfunction

// Thumbnail keeps x mod 8 and y mod 8 in {0, 1}
function automatic bit thumb_keep(input int i);
    return ((i % IMG_WIDTH) % 8 < 2) && ((i / IMG_WIDTH) % 8 < 2);
endfunction

function automatic capture_stats_t model_stats();
    capture_stats_t s;
    pixel_t         p;
    s = '0;
    s.pixel_count = pix_count_t'(PIX_COUNT);
    for (int i = 0; i < PIX_COUNT; i++) begin
        p = frame_model[i];
        // One sample per 4x4 group
        if ((i % IMG_WIDTH) % 4 == 0 && (i / IMG_WIDTH) % 4 == 0) begin
            if (p[11:5] == 7'h7f) s.highlight_count++;
            if (p[11:5] == 7'h00) s.shadow_count++;
        end
    end
    return s;
endfunction

// Fletcher-32 over byte-swapped words
function automatic checksum_t fletcher32(input word_t words[$]);
    int    a;
    int    b;
    word_t w;
    a = 0;
    b = 0;
    foreach (words[i]) begin
        w = {words[i][7:0], words[i][15:8]};
        a = (a + int'(w)) % 65535;
        b = (b + a) % 65535;
    end
    return {b[15:0], a[15:0]};
endfunction

function automatic void build_stream(input bit thumb_mode,
                                     input word_t [HEADER_WORDS-1:0] hdr);
    checksum_t c;
    exp_stream.delete();
    for (int i = 0; i < HEADER_WORDS; i++) exp_stream.push_back(hdr[i]);
    for (int i = 0; i < PIX_COUNT; i++) begin
        if (!thumb_mode || thumb_keep(i)) exp_stream.push_back(pack_pixel(frame_model[i]));
    end
    c = fletcher32(exp_stream);
    exp_trailer = {<<8{c}};
    exp_stream.push_back(exp_trailer[31:16]);
    exp_stream.push_back(exp_trailer[15:0]);
    for (int i = 0; i < PADDING_WORDS; i++) exp_stream.push_back('0);
endfunction

`endif

//--- verification/tb_img_controller.sv
`timescale 1ns/100ps

module tb_img_controller
    import img_pkg::*;
();

    localparam int IMG_WIDTH       = 16;
    localparam int IMG_HEIGHT      = 16;
    localparam int HEADER_WORDS    = 8;
    localparam int PADDING_WORDS   = 42;
    localparam int PIX_COUNT       = IMG_WIDTH * IMG_HEIGHT;
    localparam int CAPTURE_TIMEOUT = 200;
    localparam int READOUT_TIMEOUT = 5000;

    logic                     clk;
    logic                     rst_n;
    pix_in_t                  pix;
    logic                     capture_req;
    skip_t                    skip_count;
    logic                     capture_ack;
    capture_stats_t           stats;
    logic                     readout_req;
    logic                     thumb;
    word_t [HEADER_WORDS-1:0] header;
    logic                     readout_ack;
    logic                     out_valid;
    word_t                    out_data;
    logic                     out_ready = 1'b0;

    bit    random_ready;
    bit    cap_ack_q;
    bit    rd_ack_q;
    int    errors;
    int    hs_errors;
    int    start_errors;
    int    passed_tests;
    int    failed_tests;
    word_t got_stream [$];

    `include "img_model.svh"

    img_controller dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix         (pix),
        .capture_req (capture_req),
        .skip_count  (skip_count),
        .capture_ack (capture_ack),
        .stats       (stats),
        .readout_req (readout_req),
        .thumb       (thumb),
        .header      (header),
        .readout_ack (readout_ack),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Consumer stalls about one cycle in three when enabled
    always @(posedge clk) begin
        if (random_ready) out_ready <= ($urandom % 3) != 0;
        else              out_ready <= 1'b1;
    end

    // Four-phase ordering of both command handshakes
    always @(posedge clk) begin
        if (rst_n) begin
            if (capture_ack && !cap_ack_q && !capture_req) begin
                $display("capture_ack rose while capture_req was low");
                hs_errors++;
            end
            if (!capture_ack && cap_ack_q && capture_req) begin
                $display("capture_ack fell while capture_req was still high");
                hs_errors++;
            end
            if (readout_ack && !rd_ack_q && !readout_req) begin
                $display("readout_ack rose while readout_req was low");
                hs_errors++;
            end
            if (!readout_ack && rd_ack_q && readout_req) begin
                $display("readout_ack fell while readout_req was still high");
                hs_errors++;
            end
        end
        cap_ack_q <= capture_ack;
        rd_ack_q  <= readout_ack;
    end

    // ========================================================================
    // Compare tasks and bookkeeping
    // ========================================================================
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_stats(input string name, input capture_stats_t expected,
                               input capture_stats_t actual);
        if (expected !== actual) begin
            $display("Mismatch in %s stats: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_checksum(input string name, input checksum_t expected,
                                  input checksum_t actual);
        if (expected !== actual) begin
            $display("Mismatch in %s checksum: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        start_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == start_errors) begin
            passed_tests++;
            $display("Test %s: pass", name);
        end else begin
            failed_tests++;
            $display("Test %s: FAIL with %0d errors", name, errors - start_errors);
        end
    endtask

    // ========================================================================
    // Sensor side
    // ========================================================================
    task automatic drive_pix(input logic fv, input logic lv, input pixel_t d);
        @(posedge clk);
        pix <= {fv, lv, d};
    endtask

    // Roughly a quarter of the pixels are pushed to the highlight or shadow range
    function automatic pixel_t random_pixel();
        pixel_t      p;
        int unsigned r;
        p = pixel_t'($urandom);
        r = $urandom % 8;
        if (r == 0) p[11:5] = 7'h7f;
        if (r == 1) p[11:5] = 7'h00;
        return p;
    endfunction

    task automatic send_frame();
        pixel_t p;
        repeat (1 + $urandom % 3) drive_pix(1'b1, 1'b0, '0);
        for (int row = 0; row < IMG_HEIGHT; row++) begin
            for (int col = 0; col < IMG_WIDTH; col++) begin
                p = random_pixel();
                frame_model[row * IMG_WIDTH + col] = p;
                drive_pix(1'b1, 1'b1, p);
            end
            repeat (1 + $urandom % 3) drive_pix(1'b1, 1'b0, '0);
        end
        repeat (2 + $urandom % 4) drive_pix(1'b0, 1'b0, '0);
    endtask

    task automatic capture_frame(input string name, input skip_t skip);
        int cycles;
        bit acked;
        @(posedge clk);
        capture_req <= 1'b1;
        skip_count  <= skip;
        repeat (3) drive_pix(1'b0, 1'b0, '0);
        // Skipped frames go first and the model keeps only the last one
        for (int f = 0; f <= int'(skip); f++) send_frame();
        cycles = 0;
        acked  = 1'b0;
        while (!acked && cycles < CAPTURE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            acked = capture_ack;
        end
        if (!acked) begin
            $display("%s: capture_ack did not rise within %0d cycles", name, cycles);
            errors++;
        end else begin
            check_stats(name, model_stats(), stats);
        end
        capture_req <= 1'b0;
        cycles = 0;
        while (capture_ack && cycles < CAPTURE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (capture_ack) begin
            $display("%s: capture_ack stayed high after capture_req fell", name);
            errors++;
        end
    endtask

    // ========================================================================
    // Host side
    // ========================================================================
    task automatic compare_stream(input string name);
        int n;
        int k;
        if (got_stream.size() != exp_stream.size()) begin
            $display("%s: received %0d words but %0d were expected",
                     name, got_stream.size(), exp_stream.size());
            errors++;
        end
        n = (got_stream.size() < exp_stream.size()) ? got_stream.size() : exp_stream.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("%s word %0d", name, i), exp_stream[i], got_stream[i]);
        end
        k = exp_stream.size() - PADDING_WORDS - 2;
        if (got_stream.size() >= k + 2) begin
            check_checksum(name, exp_trailer, {got_stream[k], got_stream[k + 1]});
        end
    endtask

    task automatic readout_frame(input string name, input bit thumb_mode, input bit stall);
        word_t [HEADER_WORDS-1:0] hdr;
        int                       cycles;
        bit                       acked;
        for (int i = 0; i < HEADER_WORDS; i++) hdr[i] = word_t'($urandom);
        got_stream.delete();
        @(posedge clk);
        header       <= hdr;
        thumb        <= thumb_mode;
        readout_req  <= 1'b1;
        random_ready <= stall;
        cycles = 0;
        acked  = 1'b0;
        while (!acked && cycles < READOUT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (out_valid && out_ready) got_stream.push_back(out_data);
            acked = readout_ack;
        end
        if (!acked) begin
            $display("%s: readout_ack did not rise within %0d cycles", name, cycles);
            errors++;
        end
        readout_req  <= 1'b0;
        random_ready <= 1'b0;
        cycles = 0;
        // Words seen here are extra and show up as a length error
        while (readout_ack && cycles < CAPTURE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (out_valid && out_ready) got_stream.push_back(out_data);
        end
        if (readout_ack) begin
            $display("%s: readout_ack stayed high after readout_req fell", name);
            errors++;
        end
        build_stream(thumb_mode, hdr);
        compare_stream(name);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        void'($urandom(28595));
        rst_n       = 1'b0;
        pix         = '0;
        capture_req = 1'b0;
        skip_count  = '0;
        readout_req = 1'b0;
        thumb       = 1'b0;
        header      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test();
        if (capture_ack || readout_ack || out_valid) begin
            $display("An ack or out_valid is high right after reset");
            errors++;
        end
        end_test("reset_state");

        begin_test();
        capture_frame("capture_skip0", 2'd0);
        end_test("capture_skip0");

        begin_test();
        readout_frame("readout_full", 1'b0, 1'b0);
        end_test("readout_full");

        begin_test();
        capture_frame("capture_skip2", 2'd2);
        end_test("capture_skip2");

        begin_test();
        readout_frame("readout_backpressure", 1'b0, 1'b1);
        end_test("readout_backpressure");

        begin_test();
        readout_frame("readout_thumbnail", 1'b1, 1'b1);
        end_test("readout_thumbnail");

        begin_test();
        errors += hs_errors;
        end_test("handshake");

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 passed_tests + failed_tests, passed_tests, failed_tests);
        if (errors == 0 && failed_tests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verification
verilog/img_pkg.sv
verilog/pixel_capture.sv
verilog/frame_buffer.sv
verilog/fletcher_checksum.sv
verilog/readout_sequencer.sv
verilog/img_controller.sv
verification/tb_img_controller.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the img_controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_img_controller -f filelist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_img_controller > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
